// File: common/fma_pkg.sv
/*
 * FMA cell package
 * Widths, working types, IEEE-754 constants and FSM states shared by
 * the systolic floating-point multiply-accumulate cell
 */

package fma_pkg;

    // IEEE-754 single precision fields
    typedef logic [31:0] float_t;
    typedef logic [7:0]  exp_t;
    typedef logic [22:0] man_t;

    // Working exponent is signed and two bits wider so range errors show up
    typedef logic signed [9:0] wide_exp_t;

    // Full 24x24 significand product, also used for the accumulator
    typedef logic [47:0] wide_man_t;

    // Products accumulated toward one answer
    typedef logic [1:0] term_count_t;

    localparam wide_exp_t EXP_BIAS = 10'sd127;
    localparam int        MAN_BITS = 23;
    localparam wide_exp_t MAX_EXP  = 10'sd254;
    localparam wide_exp_t MIN_EXP  = 10'sd1;

    // Position of the hidden one in a normalized working significand
    localparam int LEAD_BIT = 2 * MAN_BITS;

    // Products per dot-product answer, fixed for the whole grid
    localparam int N_TERMS = 3;

    // Answer word shown after an input or range error
    localparam float_t ANSWER_ERROR = 32'hFFFF_FFFF;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        MULTIPLY,
        ALIGN,
        ACCUMULATE,
        NORMALIZE,
        OUTPUT,
        ERROR
    } fma_state_e;

endpackage

// File: common/fma_step_if.sv
/*
 * FMA stage strobes
 * Single-cycle strobes from the cell FSM to the multiplier and
 * accumulator, plus the product range flag coming back
 */

`timescale 1ns/10ps

interface fma_step_if;

    logic mul_en;
    logic align_en;
    logic add_en;
    logic norm_en;
    logic drain;
    logic flush;
    logic product_range_err;

    modport control (
        output mul_en,
        output align_en,
        output add_en,
        output norm_en,
        output drain,
        output flush,
        input  product_range_err
    );

    modport mult (
        input  mul_en,
        output product_range_err
    );

    modport accum (
        input align_en,
        input add_en,
        input norm_en,
        input drain,
        input flush
    );

endinterface

// File: hw/fma_cell/fp_multiplier.sv
/*
 * Floating-point multiplier
 * Registers the exact significand product of the two captured operands
 * with the rebiased exponent sum and flags products out of range
 */

`timescale 1ns/10ps

module fp_multiplier (
    input  logic               clk,
    input  logic               rst,
    input  fma_pkg::float_t    a_op,
    input  fma_pkg::float_t    b_op,
    fma_step_if.mult           step,
    output logic               prod_sign,
    output fma_pkg::wide_exp_t prod_exp,
    output fma_pkg::wide_man_t prod_man
);

    fma_pkg::exp_t      a_exp;
    fma_pkg::exp_t      b_exp;
    fma_pkg::man_t      a_man;
    fma_pkg::man_t      b_man;
    fma_pkg::wide_exp_t exp_sum;
    logic               any_zero;

    assign a_exp = a_op[30:fma_pkg::MAN_BITS];
    assign b_exp = b_op[30:fma_pkg::MAN_BITS];
    assign a_man = a_op[fma_pkg::MAN_BITS-1:0];
    assign b_man = b_op[fma_pkg::MAN_BITS-1:0];

    // Zero shortcut, the sign bit is ignored
    assign any_zero = (a_op[30:0] == '0) || (b_op[30:0] == '0);

    assign exp_sum = fma_pkg::wide_exp_t'({2'b00, a_exp})
                   + fma_pkg::wide_exp_t'({2'b00, b_exp})
                   - fma_pkg::EXP_BIAS;

    always_ff @(posedge clk) begin
        if (rst) begin
            step.product_range_err <= 1'b0;
        end else if (step.mul_en) begin
            step.product_range_err <= !any_zero
                && ((exp_sum > fma_pkg::MAX_EXP) || (exp_sum < fma_pkg::MIN_EXP));
        end
    end

    always_ff @(posedge clk) begin
        if (step.mul_en) begin
            if (any_zero) begin
                prod_sign <= 1'b0;
                prod_exp  <= '0;
                prod_man  <= '0;
            end else begin
                prod_sign <= a_op[31] ^ b_op[31];
                prod_exp  <= exp_sum;
                prod_man  <= fma_pkg::wide_man_t'({1'b1, a_man})
                           * fma_pkg::wide_man_t'({1'b1, b_man});
            end
        end
    end

endmodule

// File: hw/fma_cell/fp_accumulator.sv
/*
 * Floating-point accumulator
 * Aligns each product against the running sum, adds or subtracts by
 * sign, renormalizes and packs the single-precision answer on drain
 */

`timescale 1ns/10ps

module fp_accumulator (
    input  logic               clk,
    input  logic               rst,
    input  logic               prod_sign,
    input  fma_pkg::wide_exp_t prod_exp,
    input  fma_pkg::wide_man_t prod_man,
    fma_step_if.accum          step,
    output fma_pkg::float_t    answer_out
);

    logic               acc_sign;
    fma_pkg::wide_exp_t acc_exp;
    fma_pkg::wide_man_t acc_man;
    logic               p_sign;
    fma_pkg::wide_man_t p_man;
    logic               prod_carry;
    fma_pkg::wide_man_t p_man_n;
    fma_pkg::wide_exp_t p_exp_n;
    fma_pkg::wide_exp_t exp_diff;
    fma_pkg::wide_exp_t neg_diff;
    logic [5:0]         lead_zeros;
    fma_pkg::float_t    answer_word;

    // A product in [2,4) is brought to the lead bit first, dropping its lowest bit
    assign prod_carry = prod_man[fma_pkg::LEAD_BIT+1];
    assign p_man_n    = prod_carry ? prod_man >> 1 : prod_man;
    assign p_exp_n    = prod_carry ? prod_exp + 10'sd1 : prod_exp;

    assign exp_diff = acc_exp - p_exp_n;
    assign neg_diff = p_exp_n - acc_exp;

    // Distance of the leading one below the lead bit
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i <= fma_pkg::LEAD_BIT; i++) begin
            if (acc_man[i]) begin
                lead_zeros = 6'(fma_pkg::LEAD_BIT - i);
            end
        end
    end

    // Fraction is the 23 bits under the hidden one, exact zero gives +0
    assign answer_word = (acc_man == '0) ? '0 :
        {acc_sign, acc_exp[7:0], acc_man[fma_pkg::LEAD_BIT-1 -: fma_pkg::MAN_BITS]};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_sign   <= 1'b0;
            acc_exp    <= '0;
            acc_man    <= '0;
            answer_out <= '0;
        end else if (step.flush) begin
            answer_out <= fma_pkg::ANSWER_ERROR;
            acc_sign   <= 1'b0;
            acc_exp    <= '0;
            acc_man    <= '0;
        end else if (step.drain) begin
            answer_out <= answer_word;
            acc_sign   <= 1'b0;
            acc_exp    <= '0;
            acc_man    <= '0;
        end else if (step.align_en) begin
            // A zero product leaves the sum alone
            if (p_man_n != '0) begin
                if (acc_man == '0) begin
                    acc_exp <= p_exp_n;
                end else if (exp_diff < 0) begin
                    acc_man <= acc_man >> neg_diff;
                    acc_exp <= p_exp_n;
                end
            end
        end else if (step.add_en) begin
            if (acc_sign == p_sign) begin
                acc_man <= acc_man + p_man;
            end else if (p_man > acc_man) begin
                acc_man  <= p_man - acc_man;
                acc_sign <= p_sign;
            end else begin
                acc_man <= acc_man - p_man;
            end
        end else if (step.norm_en) begin
            if (acc_man == '0) begin
                acc_sign <= 1'b0;
                acc_exp  <= '0;
            end else if (acc_man[fma_pkg::LEAD_BIT+1]) begin
                acc_man <= acc_man >> 1;
                acc_exp <= acc_exp + 10'sd1;
            end else begin
                // Left shift after cancellation
                acc_man <= acc_man << lead_zeros;
                acc_exp <= acc_exp - fma_pkg::wide_exp_t'({4'b0000, lead_zeros});
            end
        end
    end

    // Aligned product, held for the add step
    always_ff @(posedge clk) begin
        if (step.align_en) begin
            p_sign <= prod_sign;
            if ((acc_man != '0) && (exp_diff > 0)) begin
                p_man <= p_man_n >> exp_diff;
            end else begin
                p_man <= p_man_n;
            end
        end
    end

endmodule

// File: hw/fma_cell/fma_cell_control.sv
/*
 * FMA cell control
 * Operand capture and checking, the stage FSM, the term counter and
 * the busy and forwarding handshake toward the neighbor cells
 */

`timescale 1ns/10ps

module fma_cell_control (
    input  logic            clk,
    input  logic            rst,
    input  fma_pkg::float_t a_in,
    input  logic            a_req_in,
    input  fma_pkg::float_t b_in,
    input  logic            b_req_in,
    input  logic            a_busy_in,
    input  logic            b_busy_in,
    output fma_pkg::float_t a_op,
    output fma_pkg::float_t b_op,
    output fma_pkg::float_t a_out,
    output logic            a_req_out,
    output fma_pkg::float_t b_out,
    output logic            b_req_out,
    output logic            busy_out,
    output logic            answer_ready,
    output logic            error_out,
    fma_step_if.control     step
);

    fma_pkg::fma_state_e  state;
    fma_pkg::fma_state_e  next_state;
    fma_pkg::term_count_t term_count;
    logic                 a_held;
    logic                 b_held;
    logic                 a_cap;
    logic                 b_cap;
    logic                 in_err;
    logic                 pair_done;
    logic                 fwd_valid;
    logic                 first_out;
    logic                 last_term;

    // Denormals, infinities and NaNs are rejected at capture
    function automatic logic operand_bad(input fma_pkg::float_t f);
        fma_pkg::exp_t e;
        fma_pkg::man_t m;
        e = f[30:fma_pkg::MAN_BITS];
        m = f[fma_pkg::MAN_BITS-1:0];
        return (e == 8'hFF) || ((e == 8'h00) && (m != '0));
    endfunction

    // Either request loads its operand while the cell is waiting
    assign a_cap     = a_req_in && ((state == fma_pkg::IDLE) || (state == fma_pkg::LOAD));
    assign b_cap     = b_req_in && ((state == fma_pkg::IDLE) || (state == fma_pkg::LOAD));
    assign in_err    = (a_cap && operand_bad(a_in)) || (b_cap && operand_bad(b_in));
    assign pair_done = (a_held || a_cap) && (b_held || b_cap);

    // fwd_valid trails OUTPUT by a cycle, so it marks later OUTPUT cycles
    assign first_out = (state == fma_pkg::OUTPUT) && !fwd_valid;
    assign last_term = term_count == fma_pkg::term_count_t'(fma_pkg::N_TERMS - 1);

    assign step.mul_en   = state == fma_pkg::MULTIPLY;
    assign step.align_en = state == fma_pkg::ALIGN;
    assign step.add_en   = state == fma_pkg::ACCUMULATE;
    assign step.norm_en  = state == fma_pkg::NORMALIZE;
    assign step.drain    = first_out && last_term;
    assign step.flush    = state == fma_pkg::ERROR;

    assign a_req_out = fwd_valid;
    assign b_req_out = fwd_valid;

    always_comb begin
        next_state = state;
        case (state)
            fma_pkg::IDLE, fma_pkg::LOAD: begin
                if (in_err) begin
                    next_state = fma_pkg::ERROR;
                end else if (pair_done) begin
                    next_state = fma_pkg::MULTIPLY;
                end else if (a_cap || b_cap || a_held || b_held) begin
                    next_state = fma_pkg::LOAD;
                end else begin
                    next_state = fma_pkg::IDLE;
                end
            end
            fma_pkg::MULTIPLY:   next_state = fma_pkg::ALIGN;
            fma_pkg::ALIGN:      next_state = fma_pkg::ACCUMULATE;
            fma_pkg::ACCUMULATE: next_state = fma_pkg::NORMALIZE;
            fma_pkg::NORMALIZE: begin
                // Product exponent out of range, nothing goes to the neighbors
                if (step.product_range_err) begin
                    next_state = fma_pkg::ERROR;
                end else begin
                    next_state = fma_pkg::OUTPUT;
                end
            end
            fma_pkg::OUTPUT: begin
                if (a_busy_in || b_busy_in) begin
                    next_state = fma_pkg::OUTPUT;
                end else begin
                    next_state = fma_pkg::IDLE;
                end
            end
            default: next_state = fma_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= fma_pkg::IDLE;
            a_held       <= 1'b0;
            b_held       <= 1'b0;
            term_count   <= '0;
            fwd_valid    <= 1'b0;
            busy_out     <= 1'b0;
            answer_ready <= 1'b0;
            error_out    <= 1'b0;
        end else begin
            state        <= next_state;
            a_held       <= (a_held || a_cap) && (next_state == fma_pkg::LOAD);
            b_held       <= (b_held || b_cap) && (next_state == fma_pkg::LOAD);
            fwd_valid    <= state == fma_pkg::OUTPUT;
            // Busy covers the pipeline and the trailing forward cycle
            busy_out     <= (next_state inside {fma_pkg::MULTIPLY, fma_pkg::ALIGN,
                                                fma_pkg::ACCUMULATE, fma_pkg::NORMALIZE,
                                                fma_pkg::OUTPUT})
                            || (state == fma_pkg::OUTPUT);
            answer_ready <= step.drain;
            error_out    <= state == fma_pkg::ERROR;
            if (state == fma_pkg::ERROR) begin
                term_count <= '0;
            end else if (first_out) begin
                term_count <= last_term ? '0 : term_count + 2'd1;
            end
        end
    end

    // Operand registers, forwarded unchanged while OUTPUT lasts
    always_ff @(posedge clk) begin
        if (a_cap) begin
            a_op <= a_in;
        end
        if (b_cap) begin
            b_op <= b_in;
        end
        if (state == fma_pkg::OUTPUT) begin
            a_out <= a_op;
            b_out <= b_op;
        end
    end

endmodule

// File: hw/fma_cell/fma_cell.sv
/*
 * FMA cell top level
 * One cell of the systolic floating-point grid: captures the operands
 * from both neighbors, accumulates their products, forwards them on
 */

`timescale 1ns/10ps

module fma_cell (
    input  logic            clk,
    input  logic            rst,

    // Operand moving across the grid
    input  fma_pkg::float_t a_in,
    input  logic            a_req_in,
    input  logic            a_busy_in,
    output fma_pkg::float_t a_out,
    output logic            a_req_out,

    // Operand moving down the grid
    input  fma_pkg::float_t b_in,
    input  logic            b_req_in,
    input  logic            b_busy_in,
    output fma_pkg::float_t b_out,
    output logic            b_req_out,

    output logic            busy_out,
    output fma_pkg::float_t answer_out,
    output logic            answer_ready,
    output logic            error_out
);

    fma_pkg::float_t    a_op;
    fma_pkg::float_t    b_op;
    logic               prod_sign;
    fma_pkg::wide_exp_t prod_exp;
    fma_pkg::wide_man_t prod_man;

    fma_step_if step ();

    fma_cell_control u_control (
        .clk          (clk),
        .rst          (rst),
        .a_in         (a_in),
        .a_req_in     (a_req_in),
        .b_in         (b_in),
        .b_req_in     (b_req_in),
        .a_busy_in    (a_busy_in),
        .b_busy_in    (b_busy_in),
        .a_op         (a_op),
        .b_op         (b_op),
        .a_out        (a_out),
        .a_req_out    (a_req_out),
        .b_out        (b_out),
        .b_req_out    (b_req_out),
        .busy_out     (busy_out),
        .answer_ready (answer_ready),
        .error_out    (error_out),
        .step         (step.control)
    );

    fp_multiplier u_multiplier (
        .clk       (clk),
        .rst       (rst),
        .a_op      (a_op),
        .b_op      (b_op),
        .step      (step.mult),
        .prod_sign (prod_sign),
        .prod_exp  (prod_exp),
        .prod_man  (prod_man)
    );

    fp_accumulator u_accumulator (
        .clk        (clk),
        .rst        (rst),
        .prod_sign  (prod_sign),
        .prod_exp   (prod_exp),
        .prod_man   (prod_man),
        .step       (step.accum),
        .answer_out (answer_out)
    );

endmodule

// File: verif/fma_cell_properties.sv
/*
 * FMA cell protocol assertions
 * Bound to the cell top level
 */

`timescale 1ns/10ps

module fma_cell_properties (
    input logic clk,
    input logic rst,
    input logic answer_ready,
    input logic error_out,
    input logic a_req_out,
    input logic b_req_out,
    input logic busy_out
);

    // An answer and an error never share a cycle
    answer_error_apart: assert property (@(posedge clk) disable iff (rst)
        !(answer_ready && error_out))
        else $error("answer_ready and error_out high together");

    answer_one_cycle: assert property (@(posedge clk) disable iff (rst)
        answer_ready |=> !answer_ready)
        else $error("answer_ready longer than one cycle");

    error_one_cycle: assert property (@(posedge clk) disable iff (rst)
        error_out |=> !error_out)
        else $error("error_out longer than one cycle");

    // Forwarding only while the cell is busy
    req_needs_busy: assert property (@(posedge clk) disable iff (rst)
        (a_req_out || b_req_out) |-> busy_out)
        else $error("req_out high while busy_out is low");

endmodule

bind fma_cell fma_cell_properties u_fma_cell_properties (
    .clk          (clk),
    .rst          (rst),
    .answer_ready (answer_ready),
    .error_out    (error_out),
    .a_req_out    (a_req_out),
    .b_req_out    (b_req_out),
    .busy_out     (busy_out)
);

// File: verif/tb_fma_cell.sv
/*
 * FMA cell testbench
 * Plays both neighbor cells, sends operand pairs in groups of three and
 * compares each answer with a reference dot product
 */

`timescale 1ns/10ps

module tb_fma_cell;

    typedef fma_pkg::float_t trio_t [3];

    logic            clk;
    logic            rst;
    fma_pkg::float_t a_in;
    logic            a_req_in;
    logic            a_busy_in;
    fma_pkg::float_t b_in;
    logic            b_req_in;
    logic            b_busy_in;
    fma_pkg::float_t a_out;
    logic            a_req_out;
    fma_pkg::float_t b_out;
    logic            b_req_out;
    logic            busy_out;
    fma_pkg::float_t answer_out;
    logic            answer_ready;
    logic            error_out;

    logic [31:0]     lfsr;
    int              errors;
    int              test_errors;
    int              tests_run;
    int              tests_failed;
    int              ans_count;
    int              err_pulses;
    string           cur_test;
    fma_pkg::float_t exp_q[$];

    fma_cell u_fma_cell (
        .clk          (clk),
        .rst          (rst),
        .a_in         (a_in),
        .a_req_in     (a_req_in),
        .a_busy_in    (a_busy_in),
        .a_out        (a_out),
        .a_req_out    (a_req_out),
        .b_in         (b_in),
        .b_req_in     (b_req_in),
        .b_busy_in    (b_busy_in),
        .b_out        (b_out),
        .b_req_out    (b_req_out),
        .busy_out     (busy_out),
        .answer_out   (answer_out),
        .answer_ready (answer_ready),
        .error_out    (error_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Exponent kept in 120..134 so products stay in range
    function automatic fma_pkg::float_t rand_operand();
        logic          s;
        fma_pkg::exp_t e;
        fma_pkg::man_t m;
        s = rand_bits(1) != 0;
        e = 8'(120 + (rand_bits(4) % 15));
        m = 23'(rand_bits(23));
        return {s, e, m};
    endfunction

    // Expected answer of three products truncated at every step
    function automatic fma_pkg::float_t ref_dot(input trio_t a, input trio_t b);
        logic [47:0] acc;
        logic [47:0] p;
        int          ae;
        int          pe;
        logic        as;
        logic        ps;
        acc = '0;
        ae  = 0;
        as  = 1'b0;
        for (int k = 0; k < 3; k++) begin
            if ((a[k][30:0] != '0) && (b[k][30:0] != '0)) begin
                p  = 48'({1'b1, a[k][22:0]}) * 48'({1'b1, b[k][22:0]});
                pe = int'(a[k][30:23]) + int'(b[k][30:23]) - 127;
                ps = a[k][31] ^ b[k][31];
                if (p[47]) begin
                    p  = p >> 1;
                    pe = pe + 1;
                end
                if (acc == '0) begin
                    ae = pe;
                end else if (ae < pe) begin
                    acc = acc >> (pe - ae);
                    ae  = pe;
                end else if (ae > pe) begin
                    p = p >> (ae - pe);
                end
                if (as == ps) begin
                    acc = acc + p;
                end else if (p > acc) begin
                    acc = p - acc;
                    as  = ps;
                end else begin
                    acc = acc - p;
                end
                if (acc == '0) begin
                    as = 1'b0;
                    ae = 0;
                end else if (acc[47]) begin
                    acc = acc >> 1;
                    ae  = ae + 1;
                end else begin
                    while (!acc[46]) begin
                        acc = acc << 1;
                        ae  = ae - 1;
                    end
                end
            end
        end
        if (acc == '0) begin
            return '0;
        end
        return {as, 8'(ae), acc[45:23]};
    endfunction

    task automatic check_float(input string what, input fma_pkg::float_t expected,
                               input fma_pkg::float_t actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("FAILED %s %s: expected %b, actual %b", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // Compares every answer pulse against the next expected value
    always @(negedge clk) begin
        if (!rst && answer_ready) begin
            ans_count++;
            if (exp_q.size() == 0) begin
                $display("Test %s: answer %h arrived with none expected", cur_test, answer_out);
                errors++;
            end else begin
                check_float("answer", exp_q.pop_front(), answer_out);
            end
        end
        if (!rst && error_out) begin
            err_pulses++;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_req(input logic level, output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            if (a_req_out == level) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Test %s: timeout, req_out never went to %b", cur_test, level);
            errors++;
        end
    endtask

    task automatic wait_answers(input int target);
        logic ok;
        ok = 1'b0;
        for (int n = 0; n < 200; n++) begin
            if (ans_count >= target) begin
                ok = 1'b1;
                break;
            end
            @(negedge clk);
        end
        if (!ok) begin
            $display("Test %s: timeout, no answer from the cell", cur_test);
            errors++;
        end
    endtask

    task automatic wait_error(output logic saw_req);
        logic ok;
        ok      = 1'b0;
        saw_req = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            if (a_req_out || b_req_out) begin
                saw_req = 1'b1;
            end
            if (error_out) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Test %s: timeout, error_out never pulsed", cur_test);
            errors++;
        end else begin
            check_float("error answer", fma_pkg::ANSWER_ERROR, answer_out);
        end
    endtask

    // Mode 0 loads both on one cycle, 1 loads a first, 2 loads b first
    task automatic load_pair(input fma_pkg::float_t a, input fma_pkg::float_t b, input int mode);
        tick();
        if (mode != 2) begin
            a_in     = a;
            a_req_in = 1'b1;
        end
        if (mode != 1) begin
            b_in     = b;
            b_req_in = 1'b1;
        end
        tick();
        a_req_in = 1'b0;
        b_req_in = 1'b0;
        if (mode == 1) begin
            b_in     = b;
            b_req_in = 1'b1;
        end else if (mode == 2) begin
            a_in     = a;
            a_req_in = 1'b1;
        end
        if (mode != 0) begin
            tick();
            a_req_in = 1'b0;
            b_req_in = 1'b0;
        end
    endtask

    task automatic send_pair(input fma_pkg::float_t a, input fma_pkg::float_t b,
                             input int mode, input int busy_cycles);
        logic ok;
        tick();
        a_busy_in = busy_cycles > 0;
        load_pair(a, b, mode);
        check_flag("busy_out after capture", 1'b1, busy_out);
        wait_req(1'b1, ok);
        if (ok) begin
            check_float("a_out", a, a_out);
            check_float("b_out", b, b_out);
            check_flag("b_req_out", 1'b1, b_req_out);
            for (int n = 0; n < busy_cycles; n++) begin
                @(negedge clk);
                check_flag("a_req_out under busy", 1'b1, a_req_out);
                check_float("a_out under busy", a, a_out);
                check_float("b_out under busy", b, b_out);
            end
            tick();
            a_busy_in = 1'b0;
            wait_req(1'b0, ok);
            if (ok) begin
                check_flag("busy_out after forward", 1'b0, busy_out);
            end
        end else begin
            tick();
            a_busy_in = 1'b0;
        end
    endtask

    task automatic run_group(input trio_t a, input trio_t b, input int mode,
                             input int busy_last, input fma_pkg::float_t expected);
        int target;
        target = ans_count + 1;
        exp_q.push_back(expected);
        for (int k = 0; k < 3; k++) begin
            send_pair(a[k], b[k], (mode == 3) ? (k % 2) + 1 : mode,
                      (k == 2) ? busy_last : 0);
        end
        wait_answers(target);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("Test %s passed", cur_test);
        end else begin
            $display("Test %s had %0d failing checks", cur_test, errors - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        trio_t           ta;
        trio_t           tb;
        logic            saw_req;
        int              base;
        fma_pkg::float_t bad_ops[2];

        lfsr         = 32'h7b9c;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ans_count    = 0;
        err_pulses   = 0;
        rst          = 1'b1;
        a_in         = '0;
        a_req_in     = 1'b0;
        a_busy_in    = 1'b0;
        b_in         = '0;
        b_req_in     = 1'b0;
        b_busy_in    = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // 1.5*2 + 3*(-0.5) + 4*2.5 = 11.5
        ta = '{32'h3FC0_0000, 32'h4040_0000, 32'h4080_0000};
        tb = '{32'h4000_0000, 32'hBF00_0000, 32'h4020_0000};

        start_test("exact_dot");
        base = ans_count;
        run_group(ta, tb, 0, 0, 32'h4138_0000);
        check_flag("one answer pulse", 1'b1, ans_count == base + 1);
        end_test();

        start_test("split_load");
        run_group(ta, tb, 3, 0, 32'h4138_0000);
        run_group(ta, tb, 3, 0, 32'h4138_0000);
        end_test();

        start_test("random_dot");
        for (int g = 0; g < 20; g++) begin
            for (int k = 0; k < 3; k++) begin
                ta[k] = rand_operand();
                tb[k] = rand_operand();
            end
            // Even groups cancel the first product exactly
            if (g % 2 == 0) begin
                ta[1] = ta[0];
                tb[1] = {~tb[0][31], tb[0][30:0]};
            end
            run_group(ta, tb, g % 3, 0, ref_dot(ta, tb));
        end
        end_test();

        start_test("back_pressure");
        ta   = '{32'h3FC0_0000, 32'h4040_0000, 32'h4080_0000};
        tb   = '{32'h4000_0000, 32'hBF00_0000, 32'h4020_0000};
        base = ans_count;
        run_group(ta, tb, 0, 6, 32'h4138_0000);
        repeat (5) @(negedge clk);
        check_flag("single answer", 1'b1, ans_count == base + 1);
        end_test();

        start_test("input_error");
        bad_ops = '{32'h7F80_0000, 32'h0000_0001};
        for (int i = 0; i < 2; i++) begin
            base = err_pulses;
            send_pair(32'h4000_0000, 32'h4000_0000, 0, 0);
            load_pair(bad_ops[i], 32'h3F80_0000, 0);
            wait_error(saw_req);
            check_flag("no forward", 1'b0, saw_req);
            @(negedge clk);
            #1;
            check_flag("error pulse", 1'b1, err_pulses == base + 1);
        end
        run_group(ta, tb, 0, 0, 32'h4138_0000);
        end_test();

        start_test("range_error");
        base = err_pulses;
        load_pair(32'h7180_0000, 32'h7180_0000, 0);
        wait_error(saw_req);
        check_flag("no forward", 1'b0, saw_req);
        @(negedge clk);
        #1;
        check_flag("error pulse", 1'b1, err_pulses == base + 1);
        run_group(ta, tb, 0, 0, 32'h4138_0000);
        end_test();

        if (exp_q.size() != 0) begin
            $display("%0d expected answers never arrived", exp_q.size());
            errors++;
        end
        $display("%0d tests, %0d failed, %0d failing checks", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
common/fma_pkg.sv
common/fma_step_if.sv
hw/fma_cell/fp_multiplier.sv
hw/fma_cell/fp_accumulator.sv
hw/fma_cell/fma_cell_control.sv
hw/fma_cell/fma_cell.sv
verif/fma_cell_properties.sv
verif/tb_fma_cell.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FMA cell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_fma_cell \
    --Mdir obj_dir -o sim_tb_fma_cell
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_fma_cell)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
